//--- dv/tb_program.svh
// columns: test name, instruction word, expected rd, expected write enable, expected data
// add_gap inserts a cycle with instr_valid_i low, data is compared only on a write

task automatic load_table();
    add_row("addi_m1",   op_i(-1, 0, 0, 1),        1, 1, 64'hffff_ffff_ffff_ffff);
    add_row("addi_5",    op_i(5, 0, 0, 2),         2, 1, 64'h5);
    add_row("lui_neg",   op_u('h80000, 3),         3, 1, 64'hffff_ffff_8000_0000);
    add_row("addi_3",    op_i(3, 0, 0, 4),         4, 1, 64'h3);
    add_row("lui_pos",   op_u('h12345, 5),         5, 1, 64'h0000_0000_1234_5000);
    add_row("add",       op_r(0, 4, 2, 0, 6),      6, 1, 64'h8);
    add_row("sub_under", op_r('h20, 2, 4, 0, 7),   7, 1, 64'hffff_ffff_ffff_fffe);
    add_row("sll",       op_r(0, 4, 2, 1, 8),      8, 1, 64'h28);
    add_row("slt_neg",   op_r(0, 2, 1, 2, 9),      9, 1, 64'h1);
    add_row("sltu_neg",  op_r(0, 2, 1, 3, 11),    11, 1, 64'h0);
    add_row("xor",       op_r(0, 4, 2, 4, 12),    12, 1, 64'h6);
    add_row("srl",       op_r(0, 4, 3, 5, 13),    13, 1, 64'h1fff_ffff_f000_0000);
    add_row("sra",       op_r('h20, 4, 3, 5, 14), 14, 1, 64'hffff_ffff_f000_0000);
    add_row("or",        op_r(0, 5, 2, 6, 15),    15, 1, 64'h0000_0000_1234_5005);
    add_row("and",       op_r(0, 5, 1, 7, 16),    16, 1, 64'h0000_0000_1234_5000);
    add_row("xori_m1",   op_i(-1, 2, 4, 17),      17, 1, 64'hffff_ffff_ffff_fffa);
    add_row("andi_neg",  op_i(-2048, 1, 7, 18),   18, 1, 64'hffff_ffff_ffff_f800);
    add_row("slti",      op_i(0, 1, 2, 19),       19, 1, 64'h1);
    add_row("sltiu_m1",  op_i(-1, 2, 3, 20),      20, 1, 64'h1);
    add_row("ori",       op_i('h7ff, 0, 6, 21),   21, 1, 64'h7ff);
    add_row("slli_63",   op_i(63, 2, 1, 22),      22, 1, 64'h8000_0000_0000_0000);
    add_row("srli_63",   op_i(63, 1, 5, 23),      23, 1, 64'h1);
    add_row("srai_63",   op_i('h43f, 3, 5, 24),   24, 1, 64'hffff_ffff_ffff_ffff);
    // dependency chain, distances 1 to 3
    add_row("dep_base",  op_i(7, 0, 0, 26),       26, 1, 64'h7);
    add_row("dep_d1",    op_i(1, 26, 0, 27),      27, 1, 64'h8);
    add_row("dep_d2",    op_r(0, 27, 26, 0, 28),  28, 1, 64'hf);
    add_row("dep_d3",    op_r('h20, 26, 28, 0, 29), 29, 1, 64'h8);
    add_row("dep_mix",   op_r(0, 28, 27, 4, 28),  28, 1, 64'h7);
    add_row("wr_x0",     op_i(9, 2, 0, 0),         0, 0, 64'h0);
    add_row("rd_x0",     op_r(0, 2, 0, 0, 30),    30, 1, 64'h5);
    add_row("illegal",   32'h0000_3283,            5, 0, 64'h0);   // ld x5, no load unit
    add_gap();
    add_row("a0_set",    op_i(42, 0, 0, 10),      10, 1, 64'h2a);
    add_gap();
    add_gap();
    add_row("a0_or",     op_r(0, 10, 5, 6, 10),   10, 1, 64'h0000_0000_1234_502a);
    add_gap();
endtask

//--- dv/tb_core_top.sv
`timescale 1ns/100ps

module tb_core_top;
    import core_pkg::*;

    localparam int XLEN       = 64;
    localparam int RST_CYCLES = 16;

    logic            clk;
    logic            rst_n_i;
    logic            instr_valid_i;
    instr_t          instr_i;
    logic            wb_valid_o;
    logic            wb_we_o;
    reg_idx_t        wb_rd_o;
    logic [XLEN-1:0] wb_data_o;
    logic [XLEN-1:0] reg_a0_o;

    string           name_q[$];
    instr_t          word_q[$];
    bit              valid_q[$];
    reg_idx_t        rd_q[$];
    bit              we_q[$];
    logic [XLEN-1:0] data_q[$];

    int              pass_cnt     = 0;
    int              fail_cnt     = 0;
    int              cycle_cnt    = 0;
    int              cycle_limit  = 0;
    int              commits_exp  = 0;
    int              commits_seen = 0;
    bit              test_bad     = 1'b0;
    logic [XLEN-1:0] a0_model     = '0;   // last committed x10 value

    core_top #(
        .XLEN(XLEN)
    ) i_dut (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .instr_valid_i(instr_valid_i),
        .instr_i      (instr_i),
        .wb_valid_o   (wb_valid_o),
        .wb_we_o      (wb_we_o),
        .wb_rd_o      (wb_rd_o),
        .wb_data_o    (wb_data_o),
        .reg_a0_o     (reg_a0_o)
    );

    always #2 clk = ~clk;   // 4 ns period

    function automatic instr_t op_r(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OP};
    endfunction

    function automatic instr_t op_i(int imm, int rs1, int f3, int rd);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], OP_IMM};
    endfunction

    function automatic instr_t op_u(int imm, int rd);
        return {imm[19:0], rd[4:0], LUI};
    endfunction

    task automatic add_row(string name, instr_t word, int rd, int we, logic [XLEN-1:0] data);
        name_q.push_back(name);
        word_q.push_back(word);
        valid_q.push_back(1'b1);
        rd_q.push_back(rd[4:0]);
        we_q.push_back(we[0]);
        data_q.push_back(data);
    endtask

    task automatic add_gap();
        name_q.push_back("gap");
        word_q.push_back('0);
        valid_q.push_back(1'b0);
        rd_q.push_back('0);
        we_q.push_back(1'b0);
        data_q.push_back('0);
    endtask

    `include "tb_program.svh"

    task automatic check_data(string name, logic [XLEN-1:0] exp, logic [XLEN-1:0] act);
        if (act !== exp) begin
            $display("** Error %s: data expected %h, actual %h", name, exp, act);
            test_bad = 1'b1;
        end
    endtask

    task automatic check_idx(string name, reg_idx_t exp, reg_idx_t act);
        if (act !== exp) begin
            $display("** Error %s: rd expected %0d, actual %0d", name, exp, act);
            test_bad = 1'b1;
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("** Error %s: expected %b, actual %b", name, exp, act);
            test_bad = 1'b1;
        end
    endtask

    task automatic finish_test(string name);
        if (test_bad) begin
            fail_cnt++;
            $display("test %s: mismatch", name);
        end else begin
            pass_cnt++;
            $display("test %s: ok", name);
        end
        test_bad = 1'b0;
    endtask

    // nothing may commit between reset release and the first instruction
    task automatic check_idle();
        repeat (3) begin
            @(negedge clk);
            check_bit("reset_idle valid", 1'b0, wb_valid_o);
            check_bit("reset_idle we", 1'b0, wb_we_o);
            check_data("reset_idle a0", '0, reg_a0_o);
        end
        finish_test("reset_idle");
    endtask

    task automatic drive_rows();
        foreach (word_q[i]) begin
            @(negedge clk);
            instr_valid_i = valid_q[i];
            instr_i       = word_q[i];
        end
        @(negedge clk);
        instr_valid_i = 1'b0;
        instr_i       = '0;
    endtask

    task automatic collect_commits();
        int row;
        row = 0;
        while (commits_seen < commits_exp) begin
            @(negedge clk);
            if (wb_valid_o) begin
                while (row < valid_q.size() && !valid_q[row]) begin
                    row++;   // gaps never commit
                end
                check_idx(name_q[row], rd_q[row], wb_rd_o);
                check_bit({name_q[row], " we"}, we_q[row], wb_we_o);
                if (we_q[row]) begin
                    check_data(name_q[row], data_q[row], wb_data_o);
                end
                if (we_q[row] && rd_q[row] == 5'd10) begin
                    check_data({name_q[row], " a0"}, a0_model, reg_a0_o);   // earlier x10
                    a0_model = data_q[row];
                end
                finish_test(name_q[row]);
                row++;
                commits_seen++;
            end
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout after %0d cycles, %0d of %0d commits never arrived",
                     cycle_cnt, commits_exp - commits_seen, commits_exp);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        clk           = 1'b0;
        rst_n_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        load_table();
        foreach (valid_q[i]) begin
            if (valid_q[i]) begin
                commits_exp++;
            end
        end
        cycle_limit = RST_CYCLES + name_q.size() + 10;
        repeat (RST_CYCLES) @(negedge clk);
        rst_n_i = 1'b1;
        check_idle();
        fork
            drive_rows();
            collect_commits();
        join
        @(negedge clk);   // last x10 write lands in the register file
        check_data("a0_final", a0_model, reg_a0_o);
        finish_test("a0_final");
        $display("tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+dv
src/core_pkg.sv
src/decode_unit.sv
src/execute_unit.sv
src/result_stage.sv
src/core_top.sv
dv/tb_core_top.sv

//--- run.sh
#!/usr/bin/env bash
# builds the core testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module tb_core_top -f filelist.f \
    || { echo "verilator build failed"; exit 1; }

sim_out="$(./obj_dir/Vtb_core_top)"
echo "$sim_out"
echo "$sim_out" | grep -qx "All checks passed" && exit 0 || exit 1

//--- src/core_pkg.sv
package core_pkg;

    // raw instruction word and register index
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_idx_t;

    localparam int NUM_REGS = 32;

    // major opcodes handled by the integer datapath
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111
    } opcode_e;

    // ALU functions
    typedef enum logic [3:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        SLL    = 4'd2,
        SLT    = 4'd3,
        SLTU   = 4'd4,
        XOR    = 4'd5,
        SRL    = 4'd6,
        SRA    = 4'd7,
        OR     = 4'd8,
        AND    = 4'd9,
        PASS_B = 4'd10   // LUI result is the immediate
    } alu_op_e;

    // decoded control word, travels with the instruction down the pipe
    typedef struct packed {
        alu_op_e  alu_op;
        logic     use_imm;   // operand B from immediate
        reg_idx_t rd;
        logic     wr_en;
        logic     legal;
        logic     valid;
    } dec_ctrl_t;

endpackage

//--- src/core_top.sv
`timescale 1ns/100ps

module core_top
    import core_pkg::*;
#(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            instr_valid_i,
    input  instr_t          instr_i,
    output logic            wb_valid_o,
    output logic            wb_we_o,
    output reg_idx_t        wb_rd_o,
    output logic [XLEN-1:0] wb_data_o,
    output logic [XLEN-1:0] reg_a0_o
);

    // decode to register file
    reg_idx_t        rs1_idx;
    reg_idx_t        rs2_idx;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;

    // decode to execute
    dec_ctrl_t       ex_ctrl;
    reg_idx_t        ex_rs1_idx;
    reg_idx_t        ex_rs2_idx;
    logic [XLEN-1:0] ex_op_a;
    logic [XLEN-1:0] ex_op_b;
    logic [XLEN-1:0] ex_imm;

    // execute result register
    dec_ctrl_t       res_ctrl;
    logic [XLEN-1:0] res_data;

    decode_unit #(
        .XLEN(XLEN)
    ) i_decode (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .instr_valid_i(instr_valid_i),
        .instr_i      (instr_i),
        .rs1_idx_o    (rs1_idx),
        .rs2_idx_o    (rs2_idx),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .ctrl_o       (ex_ctrl),
        .rs1_idx_ex_o (ex_rs1_idx),
        .rs2_idx_ex_o (ex_rs2_idx),
        .op_a_o       (ex_op_a),
        .op_b_o       (ex_op_b),
        .imm_o        (ex_imm)
    );

    execute_unit #(
        .XLEN(XLEN)
    ) i_execute (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .ctrl_i    (ex_ctrl),
        .rs1_idx_i (ex_rs1_idx),
        .rs2_idx_i (ex_rs2_idx),
        .op_a_i    (ex_op_a),
        .op_b_i    (ex_op_b),
        .imm_i     (ex_imm),
        .res_ctrl_o(res_ctrl),
        .res_data_o(res_data)
    );

    result_stage #(
        .XLEN(XLEN)
    ) i_result (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .res_ctrl_i(res_ctrl),
        .res_data_i(res_data),
        .rd1_idx_i (rs1_idx),
        .rd2_idx_i (rs2_idx),
        .rd1_data_o(rs1_data),
        .rd2_data_o(rs2_data),
        .wb_valid_o(wb_valid_o),
        .wb_we_o   (wb_we_o),
        .wb_rd_o   (wb_rd_o),
        .wb_data_o (wb_data_o),
        .reg_a0_o  (reg_a0_o)
    );

endmodule

//--- src/decode_unit.sv
`timescale 1ns/100ps

module decode_unit
    import core_pkg::*;
#(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            instr_valid_i,
    input  instr_t          instr_i,
    output reg_idx_t        rs1_idx_o,
    output reg_idx_t        rs2_idx_o,
    input  logic [XLEN-1:0] rs1_data_i,
    input  logic [XLEN-1:0] rs2_data_i,
    output dec_ctrl_t       ctrl_o,
    output reg_idx_t        rs1_idx_ex_o,
    output reg_idx_t        rs2_idx_ex_o,
    output logic [XLEN-1:0] op_a_o,
    output logic [XLEN-1:0] op_b_o,
    output logic [XLEN-1:0] imm_o
);

    logic            id_valid_q;
    instr_t          id_instr_q;
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic            shamt_ok;
    dec_ctrl_t       dec_ctrl;
    logic [XLEN-1:0] dec_imm;

    dec_ctrl_t       ctrl_q;
    reg_idx_t        rs1_idx_q;
    reg_idx_t        rs2_idx_q;
    logic [XLEN-1:0] op_a_q;
    logic [XLEN-1:0] op_b_q;
    logic [XLEN-1:0] imm_q;

    assign opcode    = id_instr_q[6:0];
    assign funct3    = id_instr_q[14:12];
    assign funct7    = id_instr_q[31:25];
    assign rs1_idx_o = id_instr_q[19:15];   // register file read request
    assign rs2_idx_o = id_instr_q[24:20];

    // shift immediates: upper bits 000000 or 010000, shamt[5] only on RV64
    assign shamt_ok = (id_instr_q[31:26] inside {6'b000000, 6'b010000}) &&
                      (XLEN == 64 || !id_instr_q[25]);

    always_comb begin
        dec_ctrl        = '0;
        dec_ctrl.valid  = id_valid_q;
        dec_ctrl.rd     = id_instr_q[11:7];
        dec_ctrl.alu_op = ADD;
        dec_imm         = {{(XLEN-12){id_instr_q[31]}}, id_instr_q[31:20]};   // I-type
        case (opcode)
            OP: begin
                dec_ctrl.legal = (funct7 == 7'b0000000) ||
                                 (funct7 == 7'b0100000 && funct3 inside {3'b000, 3'b101});
                case (funct3)
                    3'b000:  dec_ctrl.alu_op = funct7[5] ? SUB : ADD;
                    3'b001:  dec_ctrl.alu_op = SLL;
                    3'b010:  dec_ctrl.alu_op = SLT;
                    3'b011:  dec_ctrl.alu_op = SLTU;
                    3'b100:  dec_ctrl.alu_op = XOR;
                    3'b101:  dec_ctrl.alu_op = funct7[5] ? SRA : SRL;
                    3'b110:  dec_ctrl.alu_op = OR;
                    default: dec_ctrl.alu_op = AND;
                endcase
            end
            OP_IMM: begin
                dec_ctrl.use_imm = 1'b1;
                dec_ctrl.legal   = 1'b1;
                case (funct3)
                    3'b000: dec_ctrl.alu_op = ADD;
                    3'b001: begin
                        dec_ctrl.alu_op = SLL;
                        dec_ctrl.legal  = shamt_ok && !id_instr_q[30];
                    end
                    3'b010: dec_ctrl.alu_op = SLT;
                    3'b011: dec_ctrl.alu_op = SLTU;
                    3'b100: dec_ctrl.alu_op = XOR;
                    3'b101: begin
                        dec_ctrl.alu_op = id_instr_q[30] ? SRA : SRL;
                        dec_ctrl.legal  = shamt_ok;
                    end
                    3'b110:  dec_ctrl.alu_op = OR;
                    default: dec_ctrl.alu_op = AND;
                endcase
            end
            LUI: begin
                dec_ctrl.use_imm = 1'b1;
                dec_ctrl.legal   = 1'b1;
                dec_ctrl.alu_op  = PASS_B;
                dec_imm = {{(XLEN-32){id_instr_q[31]}}, id_instr_q[31:12], 12'b0};
            end
            default: ;   // unsupported, stays illegal
        endcase
        dec_ctrl.wr_en = dec_ctrl.legal;   // illegal ones commit without a write
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            id_valid_q <= 1'b0;
            ctrl_q     <= '0;
        end else begin
            id_valid_q <= instr_valid_i;
            ctrl_q     <= dec_ctrl;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid_i) begin
            id_instr_q <= instr_i;
        end
        rs1_idx_q <= (opcode == LUI) ? '0 : rs1_idx_o;   // LUI has no rs1
        rs2_idx_q <= dec_ctrl.use_imm ? '0 : rs2_idx_o;
        op_a_q    <= rs1_data_i;
        op_b_q    <= rs2_data_i;
        imm_q     <= dec_imm;
    end

    assign ctrl_o       = ctrl_q;
    assign rs1_idx_ex_o = rs1_idx_q;
    assign rs2_idx_ex_o = rs2_idx_q;
    assign op_a_o       = op_a_q;
    assign op_b_o       = op_b_q;
    assign imm_o        = imm_q;

    // legal control reaching execute came from a supported opcode one edge earlier
    a_legal_opcode: assert property (@(posedge clk) disable iff (!rst_n_i)
        ctrl_q.valid && ctrl_q.legal |-> $past(opcode) inside {OP, OP_IMM, LUI});

endmodule

//--- src/execute_unit.sv
`timescale 1ns/100ps

module execute_unit
    import core_pkg::*;
#(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            rst_n_i,
    input  dec_ctrl_t       ctrl_i,
    input  reg_idx_t        rs1_idx_i,
    input  reg_idx_t        rs2_idx_i,
    input  logic [XLEN-1:0] op_a_i,
    input  logic [XLEN-1:0] op_b_i,
    input  logic [XLEN-1:0] imm_i,
    output dec_ctrl_t       res_ctrl_o,
    output logic [XLEN-1:0] res_data_o
);

    localparam int SHW = $clog2(XLEN);   // shift amount width

    dec_ctrl_t       res_ctrl_q;
    logic [XLEN-1:0] res_data_q;
    logic            prod_writes;
    logic            fwd_a;
    logic            fwd_b;
    logic [XLEN-1:0] src_a;
    logic [XLEN-1:0] src_b;
    logic [SHW-1:0]  shamt;
    logic [XLEN-1:0] alu_res;

    // producer sitting in the result register
    assign prod_writes = res_ctrl_q.valid && res_ctrl_q.wr_en && (res_ctrl_q.rd != '0);
    assign fwd_a       = prod_writes && (res_ctrl_q.rd == rs1_idx_i);
    assign fwd_b       = prod_writes && (res_ctrl_q.rd == rs2_idx_i);

    assign src_a = fwd_a ? res_data_q : op_a_i;
    assign src_b = ctrl_i.use_imm ? imm_i : (fwd_b ? res_data_q : op_b_i);
    assign shamt = src_b[SHW-1:0];

    always_comb begin
        case (ctrl_i.alu_op)
            ADD:     alu_res = src_a + src_b;
            SUB:     alu_res = src_a - src_b;
            SLL:     alu_res = src_a << shamt;
            SLT:     alu_res = {{(XLEN-1){1'b0}}, $signed(src_a) < $signed(src_b)};
            SLTU:    alu_res = {{(XLEN-1){1'b0}}, src_a < src_b};
            XOR:     alu_res = src_a ^ src_b;
            SRL:     alu_res = src_a >> shamt;
            SRA:     alu_res = $signed(src_a) >>> shamt;
            OR:      alu_res = src_a | src_b;
            AND:     alu_res = src_a & src_b;
            PASS_B:  alu_res = src_b;   // LUI
            default: alu_res = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            res_ctrl_q <= '0;
        end else begin
            res_ctrl_q <= ctrl_i;
        end
    end

    always_ff @(posedge clk) begin
        res_data_q <= alu_res;
    end

    assign res_ctrl_o = res_ctrl_q;
    assign res_data_o = res_data_q;

    // registered logical shifts match a shift by operand B modulo XLEN
    a_shamt_range: assert property (@(posedge clk) disable iff (!rst_n_i)
        res_ctrl_q.valid && res_ctrl_q.alu_op inside {SLL, SRL} |->
            res_data_q == ((res_ctrl_q.alu_op == SLL) ?
                           ($past(src_a) << ($past(src_b) % XLEN)) :
                           ($past(src_a) >> ($past(src_b) % XLEN))));

endmodule

//--- src/result_stage.sv
`timescale 1ns/100ps

module result_stage
    import core_pkg::*;
#(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            rst_n_i,
    input  dec_ctrl_t       res_ctrl_i,
    input  logic [XLEN-1:0] res_data_i,
    input  reg_idx_t        rd1_idx_i,
    input  reg_idx_t        rd2_idx_i,
    output logic [XLEN-1:0] rd1_data_o,
    output logic [XLEN-1:0] rd2_data_o,
    output logic            wb_valid_o,
    output logic            wb_we_o,
    output reg_idx_t        wb_rd_o,
    output logic [XLEN-1:0] wb_data_o,
    output logic [XLEN-1:0] reg_a0_o
);

    localparam reg_idx_t A0_IDX = 5'd10;

    logic [XLEN-1:0] rf_q [NUM_REGS];
    logic            wr_en;

    assign wr_en = res_ctrl_i.valid && res_ctrl_i.legal && res_ctrl_i.wr_en &&
                   (res_ctrl_i.rd != '0);   // x0 is never written

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                rf_q[i] <= '0;
            end
        end else if (wr_en) begin
            rf_q[res_ctrl_i.rd] <= res_data_i;
        end
    end

    // write-through bypass for an operand read in the same cycle
    assign rd1_data_o = (wr_en && rd1_idx_i == res_ctrl_i.rd) ? res_data_i : rf_q[rd1_idx_i];
    assign rd2_data_o = (wr_en && rd2_idx_i == res_ctrl_i.rd) ? res_data_i : rf_q[rd2_idx_i];

    // commit trace
    assign wb_valid_o = res_ctrl_i.valid;
    assign wb_we_o    = wr_en;
    assign wb_rd_o    = res_ctrl_i.rd;
    assign wb_data_o  = res_data_i;
    assign reg_a0_o   = rf_q[A0_IDX];

    a_we_rd_nonzero: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_we_o |-> wb_rd_o != '0);

endmodule
